// File: list.f
+incdir+bench
hdl/mcmd_field_pkg.sv
hdl/wr_seq_pkg.sv
hdl/wr_step_counter.sv
hdl/wr_step_rom.sv
hdl/wr_cmd_encoder.sv
hdl/linear_wr_encoder.sv
bench/tb_linear_wr.sv

// File: Bender.yml
package:
  name: linear_wr_encoder

sources:
  - files:
      - hdl/mcmd_field_pkg.sv
      - hdl/wr_seq_pkg.sv
      - hdl/wr_step_counter.sv
      - hdl/wr_step_rom.sv
      - hdl/wr_cmd_encoder.sv
      - hdl/linear_wr_encoder.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_linear_wr.sv

// File: bench/wr_ref_model.svh
// reference model of the linear write sequence, included inside the testbench module
// build_expected fills exp_words and exp_weight with the words of one request
`ifndef WR_REF_MODEL_SVH
`define WR_REF_MODEL_SVH

cmd_word_t exp_words[$];    // expected words in output order
int        exp_weight[$];   // reads a word stands for when its buf_rd is set

// one row of the step table
// {rcw, pause, flags last/odt/sel/dq/toggle/nop/page/rd, reads}
function automatic logic [14:0] step_entry(input int s);
    case (s)
        0:       return {3'd4, 2'd0, 8'b0000_0000, 2'd1}; // activate
        1:       return {3'd0, 2'd1, 8'b0000_0001, 2'd2}; // pause 1, dual read
        2:       return {3'd3, 2'd0, 8'b0110_0001, 2'd1}; // first write
        3:       return {3'd0, 2'd0, 8'b0101_0001, 2'd1}; // preamble
        4:       return {3'd3, 2'd0, 8'b0111_1101, 2'd2}; // looped write, dual read
        5:       return {3'd0, 2'd2, 8'b0101_1000, 2'd1};
        6:       return {3'd0, 2'd2, 8'b0000_0000, 2'd1}; // write recovery
        7:       return {3'd5, 2'd0, 8'b0000_0010, 2'd1}; // precharge, next page
        8:       return {3'd0, 2'd2, 8'b0000_0000, 2'd1};
        default: return {3'd0, 2'd0, 8'b1000_0000, 2'd1}; // done marker
    endcase
endfunction

function automatic void build_expected(input logic [BANK_W-1:0] bank,
        input logic [ADDR_W-1:0] row, input logic [COL_W-1:0] col, input int n);
    logic [14:0] ent;
    logic [7:0]  fl;
    cmd_word_t   w;
    int          granted;       // buffer reads handed out so far
    int          s;
    int          r;
    exp_words.delete();
    exp_weight.delete();
    granted = 0;
    for (s = 0; s < 10; s++) begin
        ent = step_entry(s);
        fl  = ent[9:2];
        for (r = 0; r < ((s == 4) ? n - 1 : 1); r++) begin // loop step runs n-1 times
            w            = '0;                              // cke, dci, buf_wr stay 0
            w.rcw        = rcw_e'(ent[14:12]);
            w.bank       = bank;
            w.odt        = fl[6];
            w.sel        = fl[5];
            w.dq_en      = fl[4];
            w.dqs_en     = fl[4];
            w.dqs_toggle = fl[3];
            w.buf_rst    = fl[1];
            if (fl[0] && (granted < 2 * n)) begin           // read budget of 2n
                w.buf_rd = 1'b1;
                granted += ent[1:0];
            end
            case (ent[14:12])
                3'd4, 3'd5: begin
                    w.addr = row;                           // activate and precharge
                    w.nop  = fl[2];
                end
                3'd3: begin
                    w.addr = {5'b0_0000, col, 3'b000};      // burst aligned column
                    w.nop  = fl[2];
                end
                default: begin
                    w.addr[1:0]      = ent[11:10];          // pause cycles
                    w.addr[DONE_BIT] = fl[7];
                end
            endcase
            exp_words.push_back(w);
            exp_weight.push_back(ent[1:0]);
        end
    end
endfunction

`endif

// File: bench/tb_linear_wr.sv
// testbench of the linear write sequence generator
// random requests checked word by word against the included model, with busy starts
`timescale 1ns/1ps

module tb_linear_wr
    import mcmd_field_pkg::*;
    import wr_seq_pkg::*;
();

    localparam int          NUM_REQ      = 200;
    localparam int          RESET_CYCLES = 10;
    localparam int          CLK_PERIOD   = 4;
    localparam int          MAX_GAP      = 5;
    localparam logic [31:0] SEED         = 32'h0fa7_c141;
    localparam int          WD_CYCLES    = RESET_CYCLES + NUM_REQ * (72 + 3 + MAX_GAP + 2);

    logic              rst;          // clock
    logic              clk;          // reset
    logic              start;
    logic [BANK_W-1:0] bank_in;
    logic [ADDR_W-1:0] row_in;
    logic [COL_W-1:0]  start_col;
    logic [XFER_W-1:0] num128_in;
    cmd_word_t         enc_cmd;
    logic              enc_wr;
    logic              enc_done;

    int cyc;                         // edges since the accepting edge
    int busy_at;                     // cycle of the extra start pulse, -1 for none

    `include "wr_ref_model.svh"

    linear_wr_encoder dut (
        .rst       (rst),
        .clk       (clk),
        .start     (start),
        .bank_in   (bank_in),
        .row_in    (row_in),
        .start_col (start_col),
        .num128_in (num128_in),
        .enc_cmd   (enc_cmd),
        .enc_wr    (enc_wr),
        .enc_done  (enc_done)
    );

    always #(CLK_PERIOD / 2) rst = ~rst;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run("first mismatch ends the run");
        end
    endtask

    task automatic scramble_inputs();
        bank_in   = BANK_W'($urandom);
        row_in    = ADDR_W'($urandom);
        start_col = COL_W'($urandom);
        num128_in = XFER_W'($urandom);
    endtask

    // drive just after the rising edge, then wait to mid cycle for sampling
    task automatic next_cycle();
        @(posedge rst);
        #1;
        cyc++;
        start = (cyc == busy_at);                // pulse while busy must be ignored
        if (start || (cyc == 0)) scramble_inputs(); // latched job must not follow inputs
        @(negedge rst);
    endtask

    task automatic run_request(input int idx);
        logic [XFER_W-1:0] num;
        logic [BANK_W-1:0] bank;
        logic [ADDR_W-1:0] row;
        logic [COL_W-1:0]  col;
        int                n;
        int                k;
        int                rd_total;
        num  = (idx == 0) ? XFER_W'(1) : (idx == 1) ? '0 : XFER_W'($urandom);
        n    = (num == 0) ? 64 : int'(num);
        bank = BANK_W'($urandom);
        row  = ADDR_W'($urandom);
        col  = COL_W'($urandom);
        build_expected(bank, row, col, n);
        busy_at = ($urandom_range(0, 2) == 0) ? $urandom_range(1, n + 5) : -1;
        @(posedge rst);
        #1;
        start     = 1'b1;
        bank_in   = bank;
        row_in    = row;
        start_col = col;
        num128_in = num;
        cyc       = -1;
        next_cycle();                            // accepting edge
        while (!enc_wr) begin
            check_value("enc_done", enc_done, 0);
            if (cyc > 8) abort_run("enc_wr never rose after an accepted start");
            next_cycle();
        end
        check_value("enc_wr latency", cyc, 3);
        k        = 0;
        rd_total = 0;
        while (enc_wr) begin
            if (k >= exp_words.size()) abort_run("enc_wr stayed high past the sequence");
            check_value("enc_cmd", enc_cmd, exp_words[k]);
            check_value("enc_done", enc_done, 0);
            if (enc_cmd.buf_rd) rd_total += exp_weight[k];
            k++;
            next_cycle();
        end
        check_value("enc_wr length", k, n + 8);
        check_value("enc_done", enc_done, 1);   // right after the last word
        check_value("buffer reads", rd_total, 2 * n);
        repeat ($urandom_range(0, MAX_GAP)) begin
            next_cycle();
            check_value("enc_wr", enc_wr, 0);  // no extra sequence
            check_value("enc_done", enc_done, 0);
        end
    endtask

    initial begin
        int req;
        rst            = 1'b0;
        clk            = 1'b1;
        start          = 1'b0;
        bank_in        = '0;
        row_in         = '0;
        start_col      = '0;
        num128_in      = '0;
        cyc            = 0;
        busy_at        = -1;
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge rst);
        #1;
        clk = 1'b0;
        repeat (3) begin                         // idle outputs before any start
            @(negedge rst);
            check_value("enc_wr", enc_wr, 0);
            check_value("enc_done", enc_done, 0);
        end
        check_value("enc_cmd", enc_cmd, 0);
        for (req = 0; req < NUM_REQ; req++) run_request(req);
        next_cycle();
        check_value("enc_done", enc_done, 0);
        $display("Test completed successfully");
        $finish;
    end

    // ends a hung run
    initial begin
        #(WD_CYCLES * CLK_PERIOD);
        abort_run("watchdog expired, the DUT stopped producing its sequence");
    end

endmodule

// File: hdl/linear_wr_encoder.sv
// top of the linear write sequence generator for the DDR3 controller
// one start pulse yields N+8 command words on enc_cmd, qualified by enc_wr
`timescale 1ns/1ps

module linear_wr_encoder
    import mcmd_field_pkg::*;
    import wr_seq_pkg::*;
(
    input  logic              rst,        // clock
    input  logic              clk,        // async reset, active high
    input  logic              start,
    input  logic [BANK_W-1:0] bank_in,
    input  logic [ADDR_W-1:0] row_in,
    input  logic [COL_W-1:0]  start_col,
    input  logic [XFER_W-1:0] num128_in,  // bursts, 0 means 64
    output cmd_word_t         enc_cmd,
    output logic              enc_wr,
    output logic              enc_done
);

    logic [STEP_W-1:0] step_addr;
    logic              cnt_vld;
    wr_job_t           cnt_job;
    step_t             rom_step;
    logic              rom_vld;
    wr_job_t           rom_job;

    wr_step_counter u_counter (
        .rst       (rst),
        .clk       (clk),
        .start     (start),
        .bank_in   (bank_in),
        .row_in    (row_in),
        .start_col (start_col),
        .num128_in (num128_in),
        .step_addr (step_addr),
        .step_vld  (cnt_vld),
        .job       (cnt_job)
    );

    wr_step_rom u_rom (
        .rst        (rst),
        .clk        (clk),
        .step_addr  (step_addr),
        .step_vld   (cnt_vld),
        .job        (cnt_job),
        .step       (rom_step),
        .step_vld_q (rom_vld),
        .job_q      (rom_job)
    );

    wr_cmd_encoder u_encoder (
        .rst      (rst),
        .clk      (clk),
        .step     (rom_step),
        .step_vld (rom_vld),
        .job      (rom_job),
        .enc_cmd  (enc_cmd),
        .enc_wr   (enc_wr),
        .enc_done (enc_done)
    );

endmodule

// File: hdl/wr_cmd_encoder.sv
// stage 3 of the write sequence generator
// limits buffer reads to 2N, packs command or pause words and drives enc_wr/enc_done
`timescale 1ns/1ps

module wr_cmd_encoder
    import mcmd_field_pkg::*;
    import wr_seq_pkg::*;
(
    input  logic      rst,      // clock
    input  logic      clk,      // async reset, active high
    input  step_t     step,
    input  logic      step_vld,
    input  wr_job_t   job,
    output cmd_word_t enc_cmd,
    output logic      enc_wr,
    output logic      enc_done
);

    logic [RD_CNT_W-1:0] rd_left;   // buffer reads still allowed
    logic [RD_CNT_W-1:0] rd_dec;
    logic                rd_grant;
    cmd_word_t           word_next;

    assign rd_grant = step.buf_rd && (rd_left != '0);
    assign rd_dec   = step.dual ? RD_CNT_W'(2) : RD_CNT_W'(1); // dual step reads twice

    // read budget, loaded on the activate step
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            rd_left <= '0;
        end else if (step_vld) begin
            if (step.cmd == STEP_ACTIVATE) rd_left <= {job.count, 1'b0};
            else if (rd_grant)             rd_left <= rd_left - rd_dec;
        end
    end

    always_comb begin
        word_next            = '0;
        word_next.bank       = job.bank;
        word_next.odt        = step.odt;
        word_next.cke        = 1'b0;     // CKE stays under controller control
        word_next.sel        = step.sel;
        word_next.dq_en      = step.dq_dqs_en;
        word_next.dqs_en     = step.dq_dqs_en;
        word_next.dqs_toggle = step.dqs_toggle;
        word_next.dci        = 1'b0;
        word_next.buf_wr     = 1'b0;     // write sequence never fills the buffer
        word_next.buf_rd     = rd_grant;
        word_next.buf_rst    = step.pg_next;
        case (step.cmd)
            STEP_ACTIVATE: begin
                word_next.rcw  = RCW_ACTIVATE;
                word_next.addr = job.row;
                word_next.nop  = step.add_nop;
            end
            STEP_PRECHARGE: begin
                word_next.rcw  = RCW_PRECHARGE;
                word_next.addr = job.row; // A10 from the row
                word_next.nop  = step.add_nop;
            end
            STEP_WRITE: begin
                word_next.rcw  = RCW_WRITE;
                word_next.addr = ADDR_W'({job.col, 3'b000}); // burst aligned column
                word_next.nop  = step.add_nop;
            end
            default: begin               // pause word
                word_next.rcw                   = RCW_NOP;
                word_next.addr[PAUSE_W-1:0]     = PAUSE_W'(step.pause);
                word_next.addr[DONE_BIT]        = step.last;
                word_next.nop                   = 1'b0;
            end
        endcase
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            enc_cmd  <= '0;
            enc_wr   <= 1'b0;
            enc_done <= 1'b0;
        end else begin
            if (step_vld) enc_cmd <= word_next; // hold last word between sequences
            enc_wr   <= step_vld;
            enc_done <= enc_wr && !step_vld;  // falling edge of enc_wr
        end
    end

    // a granted read never takes more than the budget still left
    a_rd_budget: assert property (@(posedge rst) disable iff (clk)
        (step_vld && rd_grant) |-> (rd_left >= rd_dec));

endmodule

// File: hdl/wr_step_rom.sv
// stage 2 of the write sequence generator
// registered microcode table, turns a step address into the controls of one word
`timescale 1ns/1ps

module wr_step_rom
    import wr_seq_pkg::*;
(
    input  logic              rst,        // clock
    input  logic              clk,        // async reset, active high
    input  logic [STEP_W-1:0] step_addr,
    input  logic              step_vld,
    input  wr_job_t           job,
    output step_t             step,
    output logic              step_vld_q,
    output wr_job_t           job_q
);

    step_t rom_word;

    always_comb begin
        rom_word = '0;                    // unlisted flags stay low
        case (step_addr)
            4'd0: rom_word.cmd = STEP_ACTIVATE;
            4'd1: begin                   // tRCD wait while buffer starts
                rom_word.cmd    = STEP_NOP;
                rom_word.pause  = 2'd1;
                rom_word.buf_rd = 1'b1;
                rom_word.dual   = 1'b1;
            end
            4'd2: begin                   // first write
                rom_word.cmd    = STEP_WRITE;
                rom_word.buf_rd = 1'b1;
                rom_word.sel    = 1'b1;
                rom_word.odt    = 1'b1;
            end
            4'd3: begin                   // preamble, DQ/DQS driven
                rom_word.cmd       = STEP_NOP;
                rom_word.buf_rd    = 1'b1;
                rom_word.dq_dqs_en = 1'b1;
                rom_word.odt       = 1'b1;
            end
            4'd4: begin                   // looped write, nop in the gap
                rom_word.cmd        = STEP_WRITE;
                rom_word.add_nop    = 1'b1;
                rom_word.buf_rd     = 1'b1;
                rom_word.dqs_toggle = 1'b1;
                rom_word.dq_dqs_en  = 1'b1;
                rom_word.sel        = 1'b1;
                rom_word.odt        = 1'b1;
                rom_word.dual       = 1'b1;
            end
            4'd5: begin                   // last data beats
                rom_word.cmd        = STEP_NOP;
                rom_word.pause      = 2'd2;
                rom_word.dqs_toggle = 1'b1;
                rom_word.dq_dqs_en  = 1'b1;
                rom_word.odt        = 1'b1;
            end
            4'd6: begin                   // write recovery
                rom_word.cmd   = STEP_NOP;
                rom_word.pause = 2'd2;
            end
            4'd7: begin
                rom_word.cmd     = STEP_PRECHARGE;
                rom_word.pg_next = 1'b1;
            end
            4'd8: begin                   // tRP
                rom_word.cmd   = STEP_NOP;
                rom_word.pause = 2'd2;
            end
            4'd9: rom_word.last = 1'b1;   // done marker, pause 0
            default: rom_word = '0;
        endcase
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            step       <= '0;
            step_vld_q <= 1'b0;
        end else begin
            step       <= rom_word;
            step_vld_q <= step_vld;
        end
    end

    always_ff @(posedge rst) job_q <= job; // travels alongside its step

endmodule

// File: hdl/wr_step_counter.sv
// stage 1 of the write sequence generator
// latches a request on start and walks the microcode address, looping on the write step
`timescale 1ns/1ps

module wr_step_counter
    import mcmd_field_pkg::*;
    import wr_seq_pkg::*;
(
    input  logic              rst,       // clock
    input  logic              clk,       // async reset, active high
    input  logic              start,     // one cycle request strobe
    input  logic [BANK_W-1:0] bank_in,
    input  logic [ADDR_W-1:0] row_in,
    input  logic [COL_W-1:0]  start_col,
    input  logic [XFER_W-1:0] num128_in, // bursts, 0 means 64
    output logic [STEP_W-1:0] step_addr,
    output logic              step_vld,
    output wr_job_t           job
);

    typedef enum logic [1:0] {
        CNT_IDLE,                        // waiting for start
        CNT_ARM,                         // request latched, step 0 next
        CNT_RUN                          // issuing steps
    } cnt_state_e;

    cnt_state_e    state;
    logic [XFER_W:0] loop_left;          // extra cycles still to spend on LOOP_STEP
    logic          accept;

    assign accept = start && (state == CNT_IDLE); // start while busy is dropped

    // request fields, only loaded when idle
    always_ff @(posedge rst) begin
        if (accept) begin
            job.bank  <= bank_in;
            job.row   <= row_in;
            job.col   <= start_col;
            job.count <= (num128_in == '0) ? {1'b1, {XFER_W{1'b0}}} : {1'b0, num128_in};
        end
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            state     <= CNT_IDLE;
            step_addr <= '0;
            step_vld  <= 1'b0;
            loop_left <= '0;
        end else begin
            case (state)
                CNT_IDLE: begin
                    if (accept) state <= CNT_ARM;
                end
                CNT_ARM: begin
                    state     <= CNT_RUN;
                    step_addr <= '0;     // activate first
                    step_vld  <= 1'b1;
                end
                CNT_RUN: begin
                    if (step_addr == LAST_STEP) begin
                        state     <= CNT_IDLE;
                        step_vld  <= 1'b0;
                        step_addr <= '0;
                    end else if (step_addr == LOOP_STEP - 1'b1) begin
                        if (job.count == 1) begin
                            step_addr <= LOOP_STEP + 1'b1; // single burst, no loop
                        end else begin
                            step_addr <= LOOP_STEP;
                            loop_left <= job.count - 2'd2; // first loop cycle is this one
                        end
                    end else if ((step_addr == LOOP_STEP) && (loop_left != '0)) begin
                        loop_left <= loop_left - 1'b1; // hold on the write
                    end else begin
                        step_addr <= step_addr + 1'b1;
                    end
                end
                default: state <= CNT_IDLE;
            endcase
        end
    end

    // table has no entries past the done step
    a_addr_range: assert property (@(posedge rst) disable iff (clk)
        step_vld |-> (step_addr <= LAST_STEP));

endmodule

// File: hdl/wr_seq_pkg.sv
// types of the linear write sequence generator
// request fields, the step opcode and the microcode step layout
package wr_seq_pkg;

    import mcmd_field_pkg::*;

    // request field widths
    localparam int XFER_W = 6;      // number of bursts, 0 stands for 64
    localparam int COL_W  = 7;      // column in units of 8-word bursts

    // microcode addressing
    localparam int STEP_W = 4;
    localparam logic [STEP_W-1:0] LOOP_STEP = 4'd4; // repeated write
    localparam logic [STEP_W-1:0] LAST_STEP = 4'd9; // closing pause with done

    // compact command code stored per step
    typedef enum logic [1:0] {
        STEP_NOP       = 2'd0,      // pause word
        STEP_WRITE     = 2'd1,
        STEP_PRECHARGE = 2'd2,
        STEP_ACTIVATE  = 2'd3
    } step_cmd_e;

    // latched request, constant for the whole sequence
    typedef struct packed {
        logic [BANK_W-1:0] bank;
        logic [ADDR_W-1:0] row;
        logic [COL_W-1:0]  col;     // start column without the 3 burst bits
        logic [XFER_W:0]   count;   // 1..64 bursts
    } wr_job_t;

    // one microcode entry
    typedef struct packed {
        step_cmd_e  cmd;
        logic [1:0] pause;          // extra wait cycles of a pause word
        logic       buf_rd;         // step wants buffer data
        logic       dual;           // step spans two cycles, counts 2 reads
        logic       dqs_toggle;
        logic       dq_dqs_en;      // drives both dq_en and dqs_en
        logic       sel;
        logic       odt;
        logic       add_nop;        // nop after the command
        logic       pg_next;        // next buffer page
        logic       last;           // end of sequence
    } step_t;

    // number of reads the buffer holds for one request is 2*count
    localparam int RD_CNT_W = XFER_W + 2;

endpackage

// File: hdl/mcmd_field_pkg.sv
// memory command word layout shared by every stage that builds or decodes sequencer words
// also holds the RAS/CAS/WE command codes in positive logic
package mcmd_field_pkg;

    // address and bank widths of the DDR3 device
    localparam int ADDR_W   = 15;   // row or column address
    localparam int BANK_W   = 3;    // 8 banks

    // pause words reuse the address field
    localparam int PAUSE_W  = 10;   // extra cycles to wait, low address bits
    localparam int DONE_BIT = 10;   // end of sequence marker, just above the pause

    // RAS/CAS/WE in positive logic, 1 means the pin is asserted
    typedef enum logic [2:0] {
        RCW_NOP       = 3'd0,       // all high on the pins
        RCW_WRITE     = 3'd3,       // CAS+WE
        RCW_ACTIVATE  = 3'd4,       // RAS only
        RCW_PRECHARGE = 3'd5        // RAS+WE
    } rcw_e;

    // one 32-bit sequencer word, MSB first
    // a pause word keeps rcw at nop and carries pause/done in addr
    typedef struct packed {
        logic [ADDR_W-1:0] addr;    // row, column or pause/done
        logic [BANK_W-1:0] bank;    // bank address
        rcw_e              rcw;     // memory command
        logic              odt;     // enable ODT
        logic              cke;     // clock enable control
        logic              sel;     // first or second half cycle
        logic              dq_en;   // drive DQ lines
        logic              dqs_en;  // drive DQS lines
        logic              dqs_toggle; // toggle DQS with the pattern
        logic              dci;     // DCI on DQ/DQS
        logic              buf_wr;  // write external buffer
        logic              buf_rd;  // read external buffer
        logic              nop;     // insert a nop after this command
        logic              buf_rst; // advance buffer page
    } cmd_word_t;

    // the sequencer word must stay exactly 32 bits wide
    localparam int CMD_WORD_W = $bits(cmd_word_t);

    // pause field has to fit below the done bit
    localparam bit LAYOUT_OK = (PAUSE_W <= DONE_BIT) && (DONE_BIT < ADDR_W)
                               && (CMD_WORD_W == 32);

endpackage
